// File: hw/tcb_pkg.sv
////////////////////////////////////////////////////////////////////////////
// bus protocol definitions for the tightly coupled bus (TCB)
// widths, size and endianness codes, request and response payloads
// imported by every block that talks on the bus
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package tcb_pkg;

  // bus widths
  localparam int unsigned tcb_adr_w = 16;
  localparam int unsigned tcb_dat_w = 32;
  // byte lanes and the address bits that pick one
  localparam int unsigned tcb_ben_w = tcb_dat_w / 8;
  localparam int unsigned tcb_off_w = $clog2(tcb_ben_w);

  // cycles from transfer to response
  localparam int unsigned tcb_hsk_dly = 1;

  // logarithmic transfer size, 2**siz bytes
  typedef logic [1:0] tcb_siz_t;
  // largest legal size on a 32-bit path (word)
  localparam tcb_siz_t tcb_siz_max = 2'd2;

  // endianness
  typedef enum logic {
    tcb_little = 1'b0,
    tcb_big    = 1'b1
  } tcb_ndn_t;

  // manager side request, data right aligned
  typedef struct packed {
    logic                 wen;
    logic [tcb_adr_w-1:0] adr;
    tcb_siz_t             siz;
    tcb_ndn_t             ndn;
    logic [tcb_dat_w-1:0] wdt;
  } tcb_req_log_t;

  // memory side request, data placed on byte lanes
  typedef struct packed {
    logic                      wen;
    logic [tcb_adr_w-1:0]      adr;
    logic [tcb_ben_w-1:0]      ben;
    logic [tcb_ben_w-1:0][7:0] wdt;
  } tcb_req_ben_t;

  // response, sts set means error
  typedef struct packed {
    logic [tcb_dat_w-1:0] rdt;
    logic                 sts;
  } tcb_rsp_t;

endpackage

`default_nettype wire

// File: hw/mem_pkg.sv
////////////////////////////////////////////////////////////////////////////
// memory map of the two SRAM banks
// bank geometry and the address fields used by the demux and the banks
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package mem_pkg;

  // words in one bank
  localparam int unsigned mem_depth = 256;
  localparam int unsigned mem_idx_w = $clog2(mem_depth);
  typedef logic [mem_idx_w-1:0] mem_idx_t;

  // word index sits right above the byte offset
  localparam int unsigned mem_idx_lsb = 2;
  // bank select, 0x0000-0x03ff bank 0, 0x0400-0x07ff bank 1
  localparam int unsigned mem_sel_bit = 10;
  // any set bit from here up is unmapped
  localparam int unsigned mem_hi_lsb = 11;

endpackage

`default_nettype wire

// File: hw/tcb_if.sv
////////////////////////////////////////////////////////////////////////////
// TCB point to point link between a manager and a subordinate
// request payload type is a parameter, the response is shared
// keeps a copy of the last transferred request for the response side
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface tcb_if #(
  parameter type req_t = tcb_pkg::tcb_req_ben_t
)(
  input logic clk
);
  import tcb_pkg::*;

  // handshake
  logic     vld;
  logic     rdy;
  // transfer in this cycle
  logic     trn;

  // payloads
  req_t     req;
  tcb_rsp_t rsp;

  // request that the current response belongs to
  req_t     req_dly;

  assign trn = vld & rdy;

  // one register deep, matching the fixed response delay
  always_ff @(posedge clk) begin
    if (trn) begin
      req_dly <= req;
    end
  end

  // manager drives the request and samples the response
  modport man (
    output vld,
    output req,
    input  rdy,
    input  trn,
    input  rsp
  );

  // subordinate answers, and may look back at the delayed request
  modport sub (
    input  vld,
    input  req,
    output rdy,
    input  trn,
    output rsp,
    input  req_dly
  );

endinterface

`default_nettype wire

// File: hw/tcb_logsize2byteena.sv
////////////////////////////////////////////////////////////////////////////
// log size to byte enable converter for naturally aligned transfers
// places right aligned write data on byte lanes, and gathers read data
// back to the low end using the delayed request
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_logsize2byteena (
  input  logic clk,
  input  logic arst_n,
  // log size side, manager connects here
  tcb_if.sub   sub,
  // byte enable side, towards the memory
  tcb_if.man   man,
  // misaligned or oversized request
  output logic err
);
  import tcb_pkg::*;

  // address bits inside the transfer, all ones for a word
  function automatic logic [tcb_off_w-1:0] lane_msk(tcb_siz_t siz);
    case (siz)
      2'd0:    return 2'b00;
      2'd1:    return 2'b01;
      default: return 2'b11;
    endcase
  endfunction

  // offset must be a multiple of the size
  function automatic logic align_err(logic [tcb_off_w-1:0] off, tcb_siz_t siz);
    return (siz > tcb_siz_max) || (|(off & lane_msk(siz)));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // request
  ////////////////////////////////////////////////////////////////////////////

  logic [tcb_off_w-1:0]      req_off;
  logic [tcb_off_w-1:0]      req_msk;
  logic                      req_err;
  logic [tcb_ben_w-1:0]      req_ben;
  logic [tcb_ben_w-1:0][7:0] req_wdt;
  // lowest set enable added on top of the enables
  logic [tcb_ben_w-1:0]      ben_run;

  assign req_off = sub.req.adr[tcb_off_w-1:0];
  assign req_msk = lane_msk(sub.req.siz);
  assign req_err = align_err(req_off, sub.req.siz);

  // lane i carries data byte pos (little) or the mirrored one (big)
  always_comb begin
    logic [tcb_off_w-1:0] pos;
    logic [tcb_off_w-1:0] src;
    req_ben = '0;
    req_wdt = '0;
    for (int unsigned i = 0; i < tcb_ben_w; i++) begin
      pos = tcb_off_w'(i) & req_msk;
      src = (sub.req.ndn == tcb_little) ? pos : (req_msk ^ pos);
      // lanes of the aligned block only, none on error
      req_ben[i] = !req_err && ((tcb_off_w'(i) & ~req_msk) == req_off);
      req_wdt[i] = sub.req.wdt[8*src +: 8];
    end
  end

  // handshake and address go straight through
  assign man.vld = sub.vld;
  assign man.req = '{wen: sub.req.wen, adr: sub.req.adr, ben: req_ben, wdt: req_wdt};
  assign sub.rdy = man.rdy;
  assign err     = req_err;

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  logic [tcb_off_w-1:0]      rsp_off;
  logic [tcb_off_w-1:0]      rsp_msk;
  logic                      rsp_err;
  logic [tcb_ben_w-1:0][7:0] rsp_rdt;

  // decode again from the request this response answers
  assign rsp_off = sub.req_dly.adr[tcb_off_w-1:0];
  assign rsp_msk = lane_msk(sub.req_dly.siz);
  assign rsp_err = align_err(rsp_off, sub.req_dly.siz);

  // byte k comes from the lane that held it, upper bytes stay zero
  always_comb begin
    logic [tcb_off_w-1:0] src;
    logic [tcb_off_w-1:0] lane;
    rsp_rdt = '0;
    for (int unsigned k = 0; k < tcb_ben_w; k++) begin
      src  = (sub.req_dly.ndn == tcb_little) ? tcb_off_w'(k) : (rsp_msk ^ tcb_off_w'(k));
      lane = rsp_off | src;
      if ((tcb_off_w'(k) & ~rsp_msk) == '0) begin
        rsp_rdt[k] = man.rsp.rdt[8*lane +: 8];
      end
    end
  end

  assign sub.rsp = '{rdt: rsp_err ? '0 : rsp_rdt, sts: man.rsp.sts};

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  assign ben_run = man.req.ben + (man.req.ben & (~man.req.ben + 1'b1));

  // enables form one unbroken run or are all clear
  a_ben_run: assert property (
    @(posedge clk) disable iff (!arst_n)
    man.vld |-> ((ben_run & man.req.ben) == '0)
  );

endmodule

`default_nettype wire

// File: hw/tcb_demux.sv
////////////////////////////////////////////////////////////////////////////
// address decoder between the converter and the two SRAM banks
// routes each request to one bank or answers it with an error,
// and merges the bank responses one cycle later
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_demux (
  input  logic clk,
  input  logic arst_n,
  // converter flagged a misaligned request
  input  logic align_err,
  tcb_if.sub   sub,
  tcb_if.man   bank0,
  tcb_if.man   bank1
);
  import tcb_pkg::*;
  import mem_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // request decode
  ////////////////////////////////////////////////////////////////////////////

  logic req_sel;
  logic req_map;
  logic req_err;

  // bank select and mapped range
  assign req_sel = sub.req.adr[mem_sel_bit];
  assign req_map = ~|sub.req.adr[tcb_adr_w-1:mem_hi_lsb];
  assign req_err = align_err | ~req_map;

  // only the selected bank sees vld, never on error
  assign bank0.vld = sub.vld & ~req_err & ~req_sel;
  assign bank1.vld = sub.vld & ~req_err &  req_sel;

  // both banks get the same payload
  assign bank0.req = sub.req;
  assign bank1.req = sub.req;

  // errors are accepted at once, even during the sweep
  assign sub.rdy = req_err ? 1'b1 : (req_sel ? bank1.rdy : bank0.rdy);

  ////////////////////////////////////////////////////////////////////////////
  // response merge
  ////////////////////////////////////////////////////////////////////////////

  // which source answers in the next cycle
  logic rsp_sel;
  logic rsp_err;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_sel <= 1'b0;
      rsp_err <= 1'b0;
    end else if (sub.trn) begin
      rsp_sel <= req_sel;
      rsp_err <= req_err;
    end
  end

  // error answer has no data
  assign sub.rsp = rsp_err ? '{rdt: '0, sts: 1'b1} :
                   (rsp_sel ? bank1.rsp : bank0.rsp);

  // one bank at a time
  a_one_bank: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(bank0.vld && bank1.vld)
  );

endmodule

`default_nettype wire

// File: hw/tcb_mem.sv
////////////////////////////////////////////////////////////////////////////
// one SRAM bank on the byte enable bus
// byte enable writes, registered reads, cleared to zero after reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_mem (
  input  logic clk,
  input  logic arst_n,
  tcb_if.sub   sub
);
  import tcb_pkg::*;
  import mem_pkg::*;

  // storage, one word per index
  logic [tcb_ben_w-1:0][7:0] mem [mem_depth];

  logic                 clr_act;
  mem_idx_t             clr_idx;
  mem_idx_t             req_idx;
  logic [tcb_dat_w-1:0] rsp_rdt;

  assign req_idx = sub.req.adr[mem_idx_lsb +: mem_idx_w];

  ////////////////////////////////////////////////////////////////////////////
  // zeroing sweep
  ////////////////////////////////////////////////////////////////////////////

  // one word per cycle, stops after the last index
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clr_act <= 1'b1;
      clr_idx <= '0;
    end else if (clr_act) begin
      clr_idx <= clr_idx + 1'b1;
      if (clr_idx == mem_idx_t'(mem_depth - 1)) begin
        clr_act <= 1'b0;
      end
    end
  end

  // stall while the sweep runs
  assign sub.rdy = ~clr_act;

  // sweep writes, then bus writes by lane
  always_ff @(posedge clk) begin
    if (clr_act) begin
      mem[clr_idx] <= '0;
    end else if (sub.trn && sub.req.wen) begin
      for (int unsigned b = 0; b < tcb_ben_w; b++) begin
        if (sub.req.ben[b]) begin
          mem[req_idx][b] <= sub.req.wdt[b];
        end
      end
    end
  end

  // read data held until the next read
  always_ff @(posedge clk) begin
    if (sub.trn && !sub.req.wen) begin
      rsp_rdt <= mem[req_idx];
    end
  end

  // a bank never fails
  assign sub.rsp = '{rdt: rsp_rdt, sts: 1'b0};

  // sweep is done before any transfer and does not come back
  a_no_trn_clr: assert property (
    @(posedge clk) disable iff (!arst_n)
    sub.trn |-> !clr_act ##1 !clr_act
  );

endmodule

`default_nettype wire

// File: hw/tcb_top.sv
////////////////////////////////////////////////////////////////////////////
// memory subsystem top level, plain TCB ports on the outside
// converter, bank decoder and two 1 KiB SRAM banks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_top (
  input  logic                          clk,
  input  logic                          arst_n,
  // request
  input  logic                          vld,
  input  logic                          wen,
  input  logic [tcb_pkg::tcb_adr_w-1:0] adr,
  input  logic [1:0]                    siz,
  input  logic                          ndn,
  input  logic [tcb_pkg::tcb_dat_w-1:0] wdt,
  // handshake and response
  output logic                          rdy,
  output logic [tcb_pkg::tcb_dat_w-1:0] rdt,
  output logic                          sts
);
  import tcb_pkg::*;

  // misaligned request from the converter
  logic align_err;

  // links
  tcb_if #(.req_t(tcb_req_log_t)) bus_log (.clk(clk));
  tcb_if #(.req_t(tcb_req_ben_t)) bus_ben (.clk(clk));
  tcb_if #(.req_t(tcb_req_ben_t)) bus_b0  (.clk(clk));
  tcb_if #(.req_t(tcb_req_ben_t)) bus_b1  (.clk(clk));

  // plain ports onto the log size link
  assign bus_log.vld = vld;
  assign bus_log.req = '{wen: wen, adr: adr, siz: tcb_siz_t'(siz),
                         ndn: tcb_ndn_t'(ndn), wdt: wdt};
  assign rdy = bus_log.rdy;
  assign rdt = bus_log.rsp.rdt;
  assign sts = bus_log.rsp.sts;

  tcb_logsize2byteena u_conv (
    .clk    (clk),
    .arst_n (arst_n),
    .sub    (bus_log),
    .man    (bus_ben),
    .err    (align_err)
  );

  tcb_demux u_demux (
    .clk       (clk),
    .arst_n    (arst_n),
    .align_err (align_err),
    .sub       (bus_ben),
    .bank0     (bus_b0),
    .bank1     (bus_b1)
  );

  // 0x0000-0x03ff
  tcb_mem u_bank0 (
    .clk    (clk),
    .arst_n (arst_n),
    .sub    (bus_b0)
  );

  // 0x0400-0x07ff
  tcb_mem u_bank1 (
    .clk    (clk),
    .arst_n (arst_n),
    .sub    (bus_b1)
  );

endmodule

`default_nettype wire

// File: bench/tcb_tb_vectors.svh
////////////////////////////////////////////////////////////////////////////
// request table for the memory subsystem testbench
// included inside the testbench module, one row per bus transfer
////////////////////////////////////////////////////////////////////////////

// columns: wen, adr, siz, ndn (0 little, 1 big), wdt, exp_rdt, exp_sts
// exp_rdt of a write row is not compared unless exp_sts is set

localparam int unsigned n_rows = 34;

localparam row_t rows [n_rows] = '{
  // never written, one word in each bank
  '{1'b0, 16'h0000, 2'd2, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0},
  '{1'b0, 16'h0404, 2'd2, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0},
  // word, byte and half writes merged into one word
  '{1'b1, 16'h0010, 2'd2, 1'b0, 32'h1122_3344, 32'h0000_0000, 1'b0},
  '{1'b1, 16'h0011, 2'd0, 1'b0, 32'hffff_ffaa, 32'h0000_0000, 1'b0},
  '{1'b1, 16'h0012, 2'd1, 1'b0, 32'h0000_beef, 32'h0000_0000, 1'b0},
  '{1'b0, 16'h0010, 2'd2, 1'b0, 32'h0000_0000, 32'hbeef_aa44, 1'b0},
  '{1'b1, 16'h0010, 2'd1, 1'b1, 32'h0000_1234, 32'h0000_0000, 1'b0},
  '{1'b0, 16'h0010, 2'd2, 1'b0, 32'h0000_0000, 32'hbeef_3412, 1'b0},
  // half and byte reads in both byte orders
  '{1'b0, 16'h0010, 2'd1, 1'b0, 32'h0000_0000, 32'h0000_3412, 1'b0},
  '{1'b0, 16'h0010, 2'd1, 1'b1, 32'h0000_0000, 32'h0000_1234, 1'b0},
  '{1'b0, 16'h0012, 2'd1, 1'b0, 32'h0000_0000, 32'h0000_beef, 1'b0},
  '{1'b0, 16'h0012, 2'd1, 1'b1, 32'h0000_0000, 32'h0000_efbe, 1'b0},
  '{1'b0, 16'h0013, 2'd0, 1'b1, 32'h0000_0000, 32'h0000_00be, 1'b0},
  '{1'b0, 16'h0010, 2'd2, 1'b1, 32'h0000_0000, 32'h1234_efbe, 1'b0},
  '{1'b1, 16'h0014, 2'd2, 1'b1, 32'ha1b2_c3d4, 32'h0000_0000, 1'b0},
  '{1'b0, 16'h0014, 2'd2, 1'b0, 32'h0000_0000, 32'hd4c3_b2a1, 1'b0},
  '{1'b0, 16'h0015, 2'd0, 1'b0, 32'h0000_0000, 32'h0000_00b2, 1'b0},
  // misaligned and oversized, memory must not change
  '{1'b1, 16'h0011, 2'd1, 1'b0, 32'hffff_ffff, 32'h0000_0000, 1'b1},
  '{1'b1, 16'h0012, 2'd2, 1'b0, 32'hffff_ffff, 32'h0000_0000, 1'b1},
  '{1'b0, 16'h0010, 2'd3, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b1},
  '{1'b1, 16'h0014, 2'd3, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b1},
  '{1'b0, 16'h0013, 2'd1, 1'b1, 32'h0000_0000, 32'h0000_0000, 1'b1},
  '{1'b0, 16'h0010, 2'd2, 1'b0, 32'h0000_0000, 32'hbeef_3412, 1'b0},
  '{1'b0, 16'h0014, 2'd2, 1'b0, 32'h0000_0000, 32'hd4c3_b2a1, 1'b0},
  // unmapped range, then same index in bank 1
  '{1'b1, 16'h0800, 2'd2, 1'b0, 32'hdead_beef, 32'h0000_0000, 1'b1},
  '{1'b0, 16'h0800, 2'd2, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b1},
  '{1'b0, 16'hfffc, 2'd2, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b1},
  '{1'b1, 16'h0410, 2'd2, 1'b0, 32'h5566_7788, 32'h0000_0000, 1'b0},
  '{1'b0, 16'h0410, 2'd2, 1'b0, 32'h0000_0000, 32'h5566_7788, 1'b0},
  '{1'b0, 16'h0010, 2'd2, 1'b0, 32'h0000_0000, 32'hbeef_3412, 1'b0},
  '{1'b0, 16'h0412, 2'd1, 1'b1, 32'h0000_0000, 32'h0000_6655, 1'b0},
  '{1'b0, 16'h0000, 2'd2, 1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0},
  // last byte of bank 1
  '{1'b1, 16'h07ff, 2'd0, 1'b0, 32'h0000_005a, 32'h0000_0000, 1'b0},
  '{1'b0, 16'h07fc, 2'd2, 1'b0, 32'h0000_0000, 32'h5a00_0000, 1'b0}
};

// File: bench/tcb_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the TCB memory subsystem
// walks the request table with random idle gaps, checks each response
// one cycle after its transfer and prints a summary
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_tb;

  localparam int unsigned clk_period = 20;
  localparam int unsigned rst_cycles = 16;

  // one transfer and the response it should get
  typedef struct packed {
    logic        wen;
    logic [15:0] adr;
    logic [1:0]  siz;
    logic        ndn;
    logic [31:0] wdt;
    logic [31:0] exp_rdt;
    logic        exp_sts;
  } row_t;

  `include "tcb_tb_vectors.svh"

  // longest gap plus stall per row, the sweep, and reset
  localparam int unsigned wd_cycles = n_rows * 8 + 300 + rst_cycles;

  logic        clk;
  logic        arst_n;
  logic        vld;
  logic        wen;
  logic [15:0] adr;
  logic [1:0]  siz;
  logic        ndn;
  logic [31:0] wdt;
  logic        rdy;
  logic [31:0] rdt;
  logic        sts;

  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned n_b2b;

  tcb_top u_dut (
    .clk    (clk),
    .arst_n (arst_n),
    .vld    (vld),
    .wen    (wen),
    .adr    (adr),
    .siz    (siz),
    .ndn    (ndn),
    .wdt    (wdt),
    .rdy    (rdy),
    .rdt    (rdt),
    .sts    (sts)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // response sampled mid cycle, one cycle after the transfer
  task automatic check_rsp(input int unsigned idx);
    row_t        r;
    int unsigned errs_before;
    r = rows[idx];
    errs_before = n_errors;
    // write responses carry no data
    if (!r.wen || r.exp_sts) begin
      n_checks++;
      assert (rdt === r.exp_rdt) else begin
        $display("Mismatch at %0t: rdt expected %h, actual %h", $time, r.exp_rdt, rdt);
        n_errors++;
      end
    end
    n_checks++;
    assert (sts === r.exp_sts) else begin
      $display("Mismatch at %0t: sts expected %b, actual %b", $time, r.exp_sts, sts);
      n_errors++;
    end
    $display("row %2d %s adr %h siz %0d ndn %0d: %s", idx, r.wen ? "wr" : "rd",
             r.adr, r.siz, r.ndn, (n_errors == errs_before) ? "ok" : "error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    row_t        r;
    int unsigned gap;
    int unsigned stalls;
    logic        pend;
    int unsigned pend_idx;
    void'($urandom(32'h43dc_06ac));
    n_checks = 0;
    n_errors = 0;
    n_b2b = 0;
    pend = 1'b0;
    pend_idx = 0;
    arst_n <= 1'b0;
    vld <= 1'b0;
    wen <= 1'b0;
    adr <= '0;
    siz <= '0;
    ndn <= 1'b0;
    wdt <= '0;
    repeat (rst_cycles) @(posedge clk);
    arst_n <= 1'b1;
    for (int unsigned i = 0; i < n_rows; i++) begin
      r = rows[i];
      gap = $urandom_range(3, 0);
      // idle cycles, the previous response lands in the first one
      repeat (gap) begin
        @(posedge clk);
        vld <= 1'b0;
        @(negedge clk);
        if (pend) begin
          check_rsp(pend_idx);
          pend = 1'b0;
        end
      end
      if (gap == 0 && i > 0) begin
        n_b2b++;
      end
      @(posedge clk);
      vld <= 1'b1;
      wen <= r.wen;
      adr <= r.adr;
      siz <= r.siz;
      ndn <= r.ndn;
      wdt <= r.wdt;
      @(negedge clk);
      if (pend) begin
        check_rsp(pend_idx);
        pend = 1'b0;
      end
      // hold the request until it is accepted
      stalls = 0;
      while (!rdy) begin
        stalls++;
        @(negedge clk);
      end
      // only the very first bank access meets the sweep
      n_checks++;
      if (i == 0) begin
        assert (stalls > 0) else begin
          $display("row 0 was accepted without waiting for the zeroing sweep");
          n_errors++;
        end
      end else begin
        assert (stalls == 0) else begin
          $display("row %0d waited %0d cycles for rdy after the sweep", i, stalls);
          n_errors++;
        end
      end
      pend = 1'b1;
      pend_idx = i;
    end
    @(posedge clk);
    vld <= 1'b0;
    @(negedge clk);
    check_rsp(pend_idx);
    // pipelined case needs at least one zero gap
    n_checks++;
    assert (n_b2b > 0) else begin
      $display("no rows ran back to back, overlapped transfers were not exercised");
      n_errors++;
    end
    $display("rows %0d, checks %0d, back to back %0d, errors %0d",
             n_rows, n_checks, n_b2b, n_errors);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(wd_cycles * clk_period);
    $display("timeout after %0d cycles, a request was never accepted", wd_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+bench
hw/tcb_pkg.sv
hw/mem_pkg.sv
hw/tcb_if.sv
hw/tcb_logsize2byteena.sv
hw/tcb_demux.sv
hw/tcb_mem.sv
hw/tcb_top.sv
bench/tcb_tb.sv

// File: Makefile
# Verilator build and run for the TCB memory subsystem

VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= tcb_tb
LINT_TOP  ?= tcb_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG  := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
